// ==== tb.f ====
logic/radiant_pkg.sv
logic/reg_bus_decode.sv
logic/id_ctrl_regs.sv
logic/trig_inputs.sv
logic/cal_pulse_gen.sv
logic/radiant_top.sv
verif/radiant_tb.sv

// ==== Makefile ====
# Verilator simulation of the register bus and trigger front end

sim:
	verilator --binary --timing --assert --top-module radiant_tb -f tb.f -o radiant_sim
	./obj_dir/radiant_sim > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	! grep -q "CHECKS FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== verif/radiant_tb.sv ====
module radiant_tb;

    // reset 3, readback 120, mask 40, levels 260, sticky 40, pulses 500, stop 100,
    // about 1100 cycles in all, so 4000 leaves a wide margin
    localparam int MAX_CYCLES = 4000;
    // date word placed in the upper half of the date-version register
    localparam logic [15:0] DATE_CODE = 16'h3a4c;

    logic                    sysclk;
    logic                    rst_n_i;
    logic                    bus_en_i;
    logic                    bus_wr_i;
    radiant_pkg::bus_addr_t  bus_addr_i;
    radiant_pkg::bus_strb_t  bus_strb_i;
    radiant_pkg::bus_data_t  bus_wdata_i;
    radiant_pkg::bus_data_t  bus_rdata_o;
    logic                    bus_ack_o;
    radiant_pkg::chan_mask_t trig_i;
    radiant_pkg::montiming_t montiming_i;
    logic                    cal_pulse_o;

    int seed;
    int mismatches;
    int other_errors;
    int cycles;
    int gap;
    int rate_list[3];
    logic [31:0] rnd_data;
    logic [31:0] rnd_strb;
    logic [31:0] rnd_trig;
    // expected read data per outstanding access
    // a write expects zero
    logic [31:0] exp_q[$];
    string       tag_q[$];
    radiant_pkg::chan_mask_t mask_model;
    radiant_pkg::chan_mask_t sticky_model;
    radiant_pkg::chan_mask_t level_old;

    radiant_top #(
        .FIRMWARE_DATE (DATE_CODE)
    ) uut (
        .sysclk      (sysclk),
        .rst_n_i     (rst_n_i),
        .bus_en_i    (bus_en_i),
        .bus_wr_i    (bus_wr_i),
        .bus_addr_i  (bus_addr_i),
        .bus_strb_i  (bus_strb_i),
        .bus_wdata_i (bus_wdata_i),
        .bus_rdata_o (bus_rdata_o),
        .bus_ack_o   (bus_ack_o),
        .trig_i      (trig_i),
        .montiming_i (montiming_i),
        .cal_pulse_o (cal_pulse_o)
    );

    initial begin
        sysclk = 1'b0;
        forever #20 sysclk = ~sysclk;
    end

    // level the host should see after polarity flip and channel masking
    function automatic radiant_pkg::chan_mask_t ref_trig(
        input radiant_pkg::chan_mask_t raw,
        input radiant_pkg::chan_mask_t pol,
        input radiant_pkg::chan_mask_t mask
    );
        return (raw ^ pol) & ~mask;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, msg, got, exp);
            mismatches++;
        end
    endtask

    // enable held one cycle, then wait for the ack
    task automatic access(input logic wr, input logic [7:0] addr, input logic [3:0] strb,
                          input logic [31:0] wdata, input logic [31:0] exp, input string msg);
        @(negedge sysclk);
        exp_q.push_back(exp);
        tag_q.push_back(msg);
        bus_en_i    = 1'b1;
        bus_wr_i    = wr;
        bus_addr_i  = addr;
        bus_strb_i  = strb;
        bus_wdata_i = wdata;
        @(negedge sysclk);
        bus_en_i = 1'b0;
        bus_wr_i = 1'b0;
        // the slave answers on the cycle after the enable
        check({31'b0, bus_ack_o}, 32'h1, "acknowledge one cycle after enable");
        while (!bus_ack_o) @(negedge sysclk);
    endtask

    task automatic bus_write(input logic [7:0] addr, input logic [3:0] strb,
                             input logic [31:0] wdata);
        access(1'b1, addr, strb, wdata, 32'h0, "read data on write ack");
    endtask

    task automatic bus_read(input logic [7:0] addr, input logic [31:0] exp, input string msg);
        access(1'b0, addr, 4'h0, 32'h0, exp, msg);
    endtask

    // cycles from the current pulse to the next one
    task automatic pulse_gap(output int n);
        n = 0;
        do begin
            @(negedge sysclk);
            n++;
            if (n == 1)
                check({31'b0, cal_pulse_o}, 32'h0, "pulse wider than one cycle");
        end while (!cal_pulse_o);
    endtask

    // every ack is matched against the oldest queued access
    always @(negedge sysclk) begin
        if (rst_n_i && bus_ack_o) begin
            if (exp_q.size() == 0) begin
                $display("error at t=%0t: acknowledge with no access pending", $time);
                other_errors++;
            end else begin
                check(bus_rdata_o, exp_q.pop_front(), tag_q.pop_front());
            end
        end else if (bus_rdata_o !== 32'h0) begin
            check(bus_rdata_o, 32'h0, "read data while idle");
        end
    end

    always @(posedge sysclk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        seed = 32'hfe51_622d;
        rate_list = '{0, 2, 5};
        rst_n_i = 1'b0;
        bus_en_i = 1'b0;
        bus_wr_i = 1'b0;
        bus_addr_i = '0;
        bus_strb_i = '0;
        bus_wdata_i = '0;
        trig_i = '0;
        montiming_i = '0;
        repeat (3) @(negedge sysclk);
        rst_n_i = 1'b1;

        // reset values with ident as ascii RDNT
        bus_read({1'b0, radiant_pkg::ADDR_IDENT}, 32'h5244_4e54, "ident");
        bus_read({1'b0, radiant_pkg::ADDR_DATEVER}, {DATE_CODE, 4'd0, 4'd2, 8'd5},
                 "date-version");
        bus_read({1'b0, radiant_pkg::ADDR_CHAN_DISABLE}, 32'h0, "disable mask at reset");
        bus_read({1'b0, radiant_pkg::ADDR_PULSE_CTRL}, 32'h0, "pulse control at reset");
        bus_read({1'b1, radiant_pkg::ADDR_TRIG_STICKY}, 32'h0, "sticky at reset");
        repeat (100) begin
            @(negedge sysclk);
            check({31'b0, cal_pulse_o}, 32'h0, "pulse while disabled");
        end

        // lane writes under random strobes
        // the mask has no lane 3
        mask_model = '0;
        for (int i = 0; i < 6; i++) begin
            rnd_data = $random(seed);
            rnd_strb = $random(seed);
            for (int lane = 0; lane < 3; lane++) begin
                if (rnd_strb[lane])
                    mask_model[lane*8 +: 8] = rnd_data[lane*8 +: 8];
            end
            bus_write({1'b0, radiant_pkg::ADDR_CHAN_DISABLE}, rnd_strb[3:0], rnd_data);
            bus_read({1'b0, radiant_pkg::ADDR_CHAN_DISABLE}, {8'h0, mask_model}, "disable mask");
        end
        bus_write({1'b0, 7'd6}, 4'hf, 32'hffff_ffff);
        bus_read({1'b0, 7'd6}, 32'h0, "unmapped id word");
        bus_read({1'b1, 7'd5}, 32'h0, "unmapped trigger word");
        bus_read({1'b0, radiant_pkg::ADDR_CHAN_DISABLE}, {8'h0, mask_model},
                 "mask after unmapped write");

        // random levels and masks
        for (int i = 0; i < 20; i++) begin
            rnd_data = $random(seed);
            mask_model = rnd_data[23:0];
            bus_write({1'b0, radiant_pkg::ADDR_CHAN_DISABLE}, 4'hf, {8'h0, mask_model});
            rnd_trig = $random(seed);
            @(negedge sysclk);
            trig_i = rnd_trig[23:0];
            montiming_i = rnd_trig[25:24];
            repeat (3) @(negedge sysclk);
            bus_read({1'b1, radiant_pkg::ADDR_TRIG_LEVEL},
                     {8'h0, ref_trig(trig_i, radiant_pkg::TRIG_POLARITY_DEFAULT, mask_model)},
                     "trigger level");
            bus_read({1'b1, radiant_pkg::ADDR_MONTIMING},
                     {30'h0, montiming_i ^ radiant_pkg::MONTIMING_POLARITY_DEFAULT},
                     "timing monitor");
        end

        // sticky flags start from idle channels and a cleared word
        rnd_data = $random(seed);
        mask_model = rnd_data[23:0];
        bus_write({1'b0, radiant_pkg::ADDR_CHAN_DISABLE}, 4'hf, {8'h0, mask_model});
        @(negedge sysclk);
        trig_i = radiant_pkg::TRIG_POLARITY_DEFAULT;
        repeat (3) @(negedge sysclk);
        bus_write({1'b1, radiant_pkg::ADDR_TRIG_STICKY}, 4'hf, 32'h00ff_ffff);
        sticky_model = '0;
        bus_read({1'b1, radiant_pkg::ADDR_TRIG_STICKY}, 32'h0, "sticky after full clear");
        level_old = ref_trig(trig_i, radiant_pkg::TRIG_POLARITY_DEFAULT, mask_model);
        rnd_trig = $random(seed);
        @(negedge sysclk);
        trig_i = radiant_pkg::TRIG_POLARITY_DEFAULT ^ rnd_trig[23:0];
        repeat (3) @(negedge sysclk);
        // only rising edges of the masked level count
        sticky_model = sticky_model |
            (ref_trig(trig_i, radiant_pkg::TRIG_POLARITY_DEFAULT, mask_model) & ~level_old);
        bus_read({1'b1, radiant_pkg::ADDR_TRIG_STICKY}, {8'h0, sticky_model},
                 "sticky after edges");
        rnd_data = $random(seed);
        bus_write({1'b1, radiant_pkg::ADDR_TRIG_STICKY}, 4'hf, {8'h0, rnd_data[23:0]});
        sticky_model = sticky_model & ~rnd_data[23:0];
        bus_read({1'b1, radiant_pkg::ADDR_TRIG_STICKY}, {8'h0, sticky_model},
                 "sticky after partial clear");

        // calibration pulse period per rate
        for (int i = 0; i < 3; i++) begin
            bus_write({1'b0, radiant_pkg::ADDR_PULSE_CTRL}, 4'h1, (rate_list[i] << 1) | 1);
            // let the tap history refill from the new rate
            repeat (4) @(negedge sysclk);
            while (!cal_pulse_o) @(negedge sysclk);
            for (int g = 0; g < 3; g++) begin
                pulse_gap(gap);
                check(gap, 2 ** (rate_list[i] + 1), "pulse gap");
            end
        end

        // pulses stop once the enable is cleared
        bus_write({1'b0, radiant_pkg::ADDR_PULSE_CTRL}, 4'h1, 32'h0);
        repeat (2) @(negedge sysclk);
        repeat (80) begin
            check({31'b0, cal_pulse_o}, 32'h0, "pulse after disable");
            @(negedge sysclk);
        end

        repeat (2) @(negedge sysclk);
        if (exp_q.size() != 0) begin
            $display("error: %0d bus accesses were never acknowledged", exp_q.size());
            other_errors++;
        end
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== logic/radiant_top.sv ====
module radiant_top #(
    parameter int                      NUM_TRIG           = radiant_pkg::NUM_TRIG_DEFAULT,
    parameter radiant_pkg::chan_mask_t TRIG_POLARITY      = radiant_pkg::TRIG_POLARITY_DEFAULT,
    parameter radiant_pkg::montiming_t MONTIMING_POLARITY =
        radiant_pkg::MONTIMING_POLARITY_DEFAULT,
    parameter radiant_pkg::bus_data_t  IDENT              = radiant_pkg::IDENT_DEFAULT,
    // day in [4:0], month in [8:5], two-digit year in [15:9]
    parameter logic [15:0]             FIRMWARE_DATE      = 16'h0000
) (
    input  logic                    sysclk,
    input  logic                    rst_n_i,
    // board-manager register bus
    input  logic                    bus_en_i,
    input  logic                    bus_wr_i,
    input  radiant_pkg::bus_addr_t  bus_addr_i,
    input  radiant_pkg::bus_strb_t  bus_strb_i,
    input  radiant_pkg::bus_data_t  bus_wdata_i,
    output radiant_pkg::bus_data_t  bus_rdata_o,
    output logic                    bus_ack_o,
    // trigger front end
    input  radiant_pkg::chan_mask_t trig_i,
    input  radiant_pkg::montiming_t montiming_i,
    output logic                    cal_pulse_o
);

    logic                     id_en;
    logic                     trig_en;
    radiant_pkg::slave_addr_t slave_addr;
    radiant_pkg::bus_data_t   id_rdata;
    logic                     id_ack;
    radiant_pkg::bus_data_t   trig_rdata;
    logic                     trig_ack;
    radiant_pkg::chan_mask_t  chan_disable;
    logic                     pulse_en;
    radiant_pkg::pulse_rate_t pulse_rate;

    reg_bus_decode u_decode (
        .sysclk       (sysclk),
        .rst_n_i      (rst_n_i),
        .bus_en_i     (bus_en_i),
        .bus_addr_i   (bus_addr_i),
        .bus_rdata_o  (bus_rdata_o),
        .bus_ack_o    (bus_ack_o),
        .id_en_o      (id_en),
        .trig_en_o    (trig_en),
        .slave_addr_o (slave_addr),
        .id_rdata_i   (id_rdata),
        .id_ack_i     (id_ack),
        .trig_rdata_i (trig_rdata),
        .trig_ack_i   (trig_ack)
    );

    id_ctrl_regs #(
        .IDENT         (IDENT),
        .FIRMWARE_DATE (FIRMWARE_DATE)
    ) u_id (
        .sysclk         (sysclk),
        .rst_n_i        (rst_n_i),
        .en_i           (id_en),
        .wr_i           (bus_wr_i),
        .addr_i         (slave_addr),
        .strb_i         (bus_strb_i),
        .wdata_i        (bus_wdata_i),
        .rdata_o        (id_rdata),
        .ack_o          (id_ack),
        .chan_disable_o (chan_disable),
        .pulse_en_o     (pulse_en),
        .pulse_rate_o   (pulse_rate)
    );

    // strobes are ignored here, every write covers the full word
    trig_inputs #(
        .NUM_TRIG           (NUM_TRIG),
        .TRIG_POLARITY      (TRIG_POLARITY),
        .MONTIMING_POLARITY (MONTIMING_POLARITY)
    ) u_trig (
        .sysclk         (sysclk),
        .rst_n_i        (rst_n_i),
        .en_i           (trig_en),
        .wr_i           (bus_wr_i),
        .addr_i         (slave_addr),
        .wdata_i        (bus_wdata_i),
        .rdata_o        (trig_rdata),
        .ack_o          (trig_ack),
        .chan_disable_i (chan_disable),
        .trig_i         (trig_i),
        .montiming_i    (montiming_i)
    );

    cal_pulse_gen u_pulse (
        .sysclk  (sysclk),
        .rst_n_i (rst_n_i),
        .en_i    (pulse_en),
        .rate_i  (pulse_rate),
        .pulse_o (cal_pulse_o)
    );

endmodule

// ==== logic/cal_pulse_gen.sv ====
module cal_pulse_gen (
    input  logic                     sysclk,
    input  logic                     rst_n_i,
    input  logic                     en_i,
    input  radiant_pkg::pulse_rate_t rate_i,
    output logic                     pulse_o
);

    localparam int CNT_W = 25;

    logic [CNT_W-1:0] counter_q;
    // history of the selected counter bit
    logic [1:0]       catch_q;
    logic             pulse_q;

    always_ff @(posedge sysclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            counter_q <= '0;
            catch_q   <= '0;
            pulse_q   <= 1'b0;
        end else begin
            // free running, never stopped by the enable
            counter_q <= counter_q + CNT_W'(1);
            // bit R rises once every 2^(R+1) cycles
            catch_q   <= {catch_q[0], counter_q[rate_i]};
            // one-cycle strobe on the rising edge of the tap
            pulse_q   <= en_i & catch_q[0] & ~catch_q[1];
        end
    end

    assign pulse_o = pulse_q;

    // even at rate 0 the tap needs two cycles per edge
    single_cycle_pulse: assert property (
        @(posedge sysclk) disable iff (!rst_n_i)
        pulse_o |=> !pulse_o
    );

endmodule

// ==== logic/trig_inputs.sv ====
module trig_inputs #(
    parameter int                     NUM_TRIG           = radiant_pkg::NUM_TRIG_DEFAULT,
    parameter logic [NUM_TRIG-1:0]    TRIG_POLARITY      = radiant_pkg::TRIG_POLARITY_DEFAULT,
    parameter radiant_pkg::montiming_t MONTIMING_POLARITY =
        radiant_pkg::MONTIMING_POLARITY_DEFAULT
) (
    input  logic                      sysclk,
    input  logic                      rst_n_i,
    // slave bus
    input  logic                      en_i,
    input  logic                      wr_i,
    input  radiant_pkg::slave_addr_t  addr_i,
    input  radiant_pkg::bus_data_t    wdata_i,
    output radiant_pkg::bus_data_t    rdata_o,
    output logic                      ack_o,
    // channel mask from the control slave
    input  logic [NUM_TRIG-1:0]       chan_disable_i,
    // comparator and monitor inputs
    input  logic [NUM_TRIG-1:0]       trig_i,
    input  radiant_pkg::montiming_t   montiming_i
);

    logic [NUM_TRIG-1:0]     trig_s1;
    logic [NUM_TRIG-1:0]     trig_s2;
    radiant_pkg::montiming_t mt_s1;
    radiant_pkg::montiming_t mt_s2;
    logic [NUM_TRIG-1:0]     level;
    logic [NUM_TRIG-1:0]     level_q;
    logic [NUM_TRIG-1:0]     rise;
    logic [NUM_TRIG-1:0]     sticky_q;
    logic [NUM_TRIG-1:0]     sticky_clr;
    logic                    wr_stb;
    logic                    rd_stb;
    radiant_pkg::bus_data_t  rd_mux;
    radiant_pkg::bus_data_t  rdata_q;
    logic                    ack_q;

    // flip to positive-true, then two register stages
    always_ff @(posedge sysclk) begin
        trig_s1 <= trig_i ^ TRIG_POLARITY;
        trig_s2 <= trig_s1;
        mt_s1   <= montiming_i ^ MONTIMING_POLARITY;
        mt_s2   <= mt_s1;
    end

    // disabled channels read as idle
    assign level = trig_s2 & ~chan_disable_i;
    assign rise  = level & ~level_q;

    assign wr_stb = en_i & wr_i;
    assign rd_stb = en_i & ~wr_i;

    // write-one-to-clear on the sticky word
    assign sticky_clr = (wr_stb && addr_i == radiant_pkg::ADDR_TRIG_STICKY) ?
                        wdata_i[NUM_TRIG-1:0] : '0;

    always_ff @(posedge sysclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            // starts high so a channel already asserted at reset release is no edge
            level_q  <= '1;
            sticky_q <= '0;
        end else begin
            level_q  <= level;
            // a new edge beats a clear in the same cycle
            sticky_q <= (sticky_q & ~sticky_clr) | rise;
        end
    end

    always_comb begin
        rd_mux = '0;
        case (addr_i)
            radiant_pkg::ADDR_TRIG_LEVEL:  rd_mux[NUM_TRIG-1:0] = level;
            radiant_pkg::ADDR_TRIG_STICKY: rd_mux[NUM_TRIG-1:0] = sticky_q;
            radiant_pkg::ADDR_MONTIMING:   rd_mux[$bits(radiant_pkg::montiming_t)-1:0] = mt_s2;
            default:                       rd_mux = '0;
        endcase
    end

    always_ff @(posedge sysclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q   <= 1'b0;
            rdata_q <= '0;
        end else begin
            ack_q   <= en_i;
            rdata_q <= rd_stb ? rd_mux : '0;
        end
    end

    assign rdata_o = rdata_q;
    assign ack_o   = ack_q;

    // mask from the control slave must keep a channel out of the sticky word
    no_sticky_when_disabled: assert property (
        @(posedge sysclk) disable iff (!rst_n_i)
        (sticky_q & ~$past(sticky_q) & $past(chan_disable_i)) == '0
    );

endmodule

// ==== logic/id_ctrl_regs.sv ====
module id_ctrl_regs #(
    parameter radiant_pkg::bus_data_t IDENT         = radiant_pkg::IDENT_DEFAULT,
    parameter logic [15:0]            FIRMWARE_DATE = 16'h0000
) (
    input  logic                      sysclk,
    input  logic                      rst_n_i,
    // slave bus
    input  logic                      en_i,
    input  logic                      wr_i,
    input  radiant_pkg::slave_addr_t  addr_i,
    input  radiant_pkg::bus_strb_t    strb_i,
    input  radiant_pkg::bus_data_t    wdata_i,
    output radiant_pkg::bus_data_t    rdata_o,
    output logic                      ack_o,
    // side-band controls
    output radiant_pkg::chan_mask_t   chan_disable_o,
    output logic                      pulse_en_o,
    output radiant_pkg::pulse_rate_t  pulse_rate_o
);

    // date in the upper half, firmware version in the lower
    localparam radiant_pkg::bus_data_t DATEVERSION = {FIRMWARE_DATE, radiant_pkg::VERSION_DEFAULT};
    // byte lanes covered by the disable mask
    localparam int NUM_LANES = $bits(radiant_pkg::chan_mask_t) / 8;

    logic                     wr_stb;
    logic                     rd_stb;
    radiant_pkg::bus_data_t   rd_mux;
    radiant_pkg::bus_data_t   rdata_q;
    logic                     ack_q;
    radiant_pkg::chan_mask_t  chan_disable_q;
    logic                     pulse_en_q;
    radiant_pkg::pulse_rate_t pulse_rate_q;

    assign wr_stb = en_i & wr_i;
    assign rd_stb = en_i & ~wr_i;

    // readback select, unmapped words read as zero
    always_comb begin
        rd_mux = '0;
        case (addr_i)
            radiant_pkg::ADDR_IDENT:        rd_mux = IDENT;
            radiant_pkg::ADDR_DATEVER:      rd_mux = DATEVERSION;
            radiant_pkg::ADDR_CHAN_DISABLE: rd_mux[NUM_LANES*8-1:0] = chan_disable_q;
            radiant_pkg::ADDR_PULSE_CTRL: begin
                rd_mux[radiant_pkg::PULSE_EN_BIT] = pulse_en_q;
                rd_mux[radiant_pkg::PULSE_RATE_MSB:radiant_pkg::PULSE_RATE_LSB] = pulse_rate_q;
            end
            default:                        rd_mux = '0;
        endcase
    end

    // every access is answered one cycle later, writes included
    always_ff @(posedge sysclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q   <= 1'b0;
            rdata_q <= '0;
        end else begin
            ack_q   <= en_i;
            // data only rides along with a read ack
            rdata_q <= rd_stb ? rd_mux : '0;
        end
    end

    always_ff @(posedge sysclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            chan_disable_q <= '0;
            pulse_en_q     <= 1'b0;
            pulse_rate_q   <= '0;
        end else if (wr_stb) begin
            // disable mask is written lane by lane
            if (addr_i == radiant_pkg::ADDR_CHAN_DISABLE) begin
                for (int lane = 0; lane < NUM_LANES; lane++) begin
                    if (strb_i[lane]) begin
                        chan_disable_q[lane*8 +: 8] <= wdata_i[lane*8 +: 8];
                    end
                end
            end
            // pulse control lives entirely in byte 0
            if (addr_i == radiant_pkg::ADDR_PULSE_CTRL && strb_i[0]) begin
                pulse_en_q   <= wdata_i[radiant_pkg::PULSE_EN_BIT];
                pulse_rate_q <= wdata_i[radiant_pkg::PULSE_RATE_MSB:radiant_pkg::PULSE_RATE_LSB];
            end
        end
    end

    assign rdata_o        = rdata_q;
    assign ack_o          = ack_q;
    assign chan_disable_o = chan_disable_q;
    assign pulse_en_o     = pulse_en_q;
    assign pulse_rate_o   = pulse_rate_q;

    // no spurious acks, the host relies on this to pace its accesses
    ack_follows_en: assert property (
        @(posedge sysclk) disable iff (!rst_n_i)
        ack_o |-> $past(en_i)
    );

endmodule

// ==== logic/reg_bus_decode.sv ====
module reg_bus_decode (
    input  logic                     sysclk,
    input  logic                     rst_n_i,
    // host side
    input  logic                     bus_en_i,
    input  radiant_pkg::bus_addr_t   bus_addr_i,
    output radiant_pkg::bus_data_t   bus_rdata_o,
    output logic                     bus_ack_o,
    // slave side
    output logic                     id_en_o,
    output logic                     trig_en_o,
    output radiant_pkg::slave_addr_t slave_addr_o,
    input  radiant_pkg::bus_data_t   id_rdata_i,
    input  logic                     id_ack_i,
    input  radiant_pkg::bus_data_t   trig_rdata_i,
    input  logic                     trig_ack_i
);

    // top address bit picks the slave
    localparam int SEL_BIT = $bits(radiant_pkg::bus_addr_t) - 1;

    logic sel_trig;

    assign sel_trig = bus_addr_i[SEL_BIT];

    // 0 = ident/control, 1 = trigger front end
    assign id_en_o   = bus_en_i & ~sel_trig;
    assign trig_en_o = bus_en_i & sel_trig;

    // both slaves share the low address bits
    assign slave_addr_o = bus_addr_i[SEL_BIT-1:0];

    // slaves hold rdata at zero when idle, so an OR is enough
    assign bus_rdata_o = id_rdata_i | trig_rdata_i;
    assign bus_ack_o   = id_ack_i | trig_ack_i;

    // only one slave may ever answer a given access
    one_slave_ack: assert property (
        @(posedge sysclk) disable iff (!rst_n_i)
        !(id_ack_i && trig_ack_i)
    );

endmodule

// ==== logic/radiant_pkg.sv ====
package radiant_pkg;

    // register bus as the board-manager link presents it
    typedef logic [7:0]  bus_addr_t;
    typedef logic [31:0] bus_data_t;
    typedef logic [3:0]  bus_strb_t;
    // word address inside one slave, select bit stripped off
    typedef logic [6:0]  slave_addr_t;

    // one bit per trigger comparator
    typedef logic [23:0] chan_mask_t;
    // the two timing-monitor inputs
    typedef logic [1:0]  montiming_t;
    // counter bit used as the calibration pulse source
    typedef logic [2:0]  pulse_rate_t;

    localparam int NUM_TRIG_DEFAULT = 24;

    // ascii device ident
    localparam bus_data_t IDENT_DEFAULT = "RDNT";
    // major in [15:12], minor in [11:8], revision in [7:0]
    localparam logic [15:0] VERSION_DEFAULT = {4'd0, 4'd2, 8'd5};

    // comparators swing negative, so a set bit means trig sits on the P input
    localparam chan_mask_t TRIG_POLARITY_DEFAULT = 24'b011011001001001010010110;
    // both monitor pairs are swapped on the board
    localparam montiming_t MONTIMING_POLARITY_DEFAULT = 2'b11;

    // identification and control slave
    localparam slave_addr_t ADDR_IDENT        = 7'd0;
    localparam slave_addr_t ADDR_DATEVER      = 7'd1;
    localparam slave_addr_t ADDR_CHAN_DISABLE = 7'd2;
    localparam slave_addr_t ADDR_PULSE_CTRL   = 7'd3;

    // trigger slave
    localparam slave_addr_t ADDR_TRIG_LEVEL  = 7'd0;
    localparam slave_addr_t ADDR_TRIG_STICKY = 7'd1;
    localparam slave_addr_t ADDR_MONTIMING   = 7'd2;

    // pulse control register fields
    localparam int PULSE_EN_BIT   = 0;
    localparam int PULSE_RATE_LSB = 1;
    localparam int PULSE_RATE_MSB = 3;

endpackage
